// File: design/can_filter_pkg.sv
// CAN acceptance filter
// shared widths and pipeline types
package can_filter_pkg;

  // filter bank size
  localparam int num_filters  = 8;
  localparam int filter_idx_w = 3;

  // identifier widths, standard and extended
  localparam int std_id_w = 11;
  localparam int ext_id_w = 29;

  // identifier normalized to the extended width
  typedef logic [ext_id_w-1:0] can_id_t;

  typedef logic [filter_idx_w-1:0] filter_idx_t;

  // one bit per filter, bit 0 is filter 0
  typedef logic [num_filters-1:0] hit_vec_t;

  // one filter entry as written by software
  typedef struct packed {
    logic    enable;
    logic    ext;
    can_id_t mask;
    can_id_t value;
  } filter_entry_t;

  // output of the decode stage
  typedef struct packed {
    can_id_t id;
    logic    ext;
  } decoded_id_t;

  // final verdict for one frame
  typedef struct packed {
    logic        accepted;
    filter_idx_t hit_index;
  } match_result_t;

endpackage

// File: design/filter_bank.sv
// Acceptance filter register bank
`timescale 1ns/10ps

module filter_bank (
  input  logic                                                     clk,
  input  logic                                                     rst_n,
  input  logic                                                     cfg_wr,
  input  can_filter_pkg::filter_idx_t                              cfg_index,
  input  can_filter_pkg::filter_entry_t                            cfg_entry,
  output can_filter_pkg::filter_entry_t [can_filter_pkg::num_filters-1:0] filter_table
);

  import can_filter_pkg::*;

  // entry after format cleanup
  filter_entry_t wr_entry;

  // a standard filter keeps only the low 11 bits of mask and value,
  // so it never tests bits a standard ID does not carry
  always_comb begin
    wr_entry = cfg_entry;
    if (!cfg_entry.ext) begin
      wr_entry.mask[ext_id_w-1:std_id_w]  = '0;
      wr_entry.value[ext_id_w-1:std_id_w] = '0;
    end
  end

  // all entries cleared on reset, so every filter starts disabled
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      filter_table <= '0;
    end else if (cfg_wr) begin
      filter_table[cfg_index] <= wr_entry;
    end
  end

endmodule

// File: design/id_decode.sv
// Receive ID decode stage
`timescale 1ns/10ps

module id_decode (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        id_valid,
  input  can_filter_pkg::can_id_t     rx_id,
  input  logic                        rx_ide,
  output logic                        dec_valid,
  output can_filter_pkg::decoded_id_t dec_id
);

  import can_filter_pkg::*;

  decoded_id_t norm_id;

  // standard frames only carry 11 bits, upper field forced to zero
  always_comb begin
    norm_id.id  = rx_id;
    norm_id.ext = rx_ide;
    if (!rx_ide) begin
      norm_id.id[ext_id_w-1:std_id_w] = '0;
    end
  end

  // strobe follows the input one edge later
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= id_valid;
    end
  end

  // payload only loads with the strobe
  always_ff @(posedge clk) begin
    if (id_valid) begin
      dec_id <= norm_id;
    end
  end

endmodule

// File: design/mask_match.sv
// Parallel mask and compare against all filters
`timescale 1ns/10ps

module mask_match (
  input  logic                                                     clk,
  input  logic                                                     rst_n,
  input  logic                                                     dec_valid,
  input  can_filter_pkg::decoded_id_t                              dec_id,
  input  can_filter_pkg::filter_entry_t [can_filter_pkg::num_filters-1:0] filter_table,
  output logic                                                     hit_valid,
  output can_filter_pkg::hit_vec_t                                 hits
);

  import can_filter_pkg::*;

  // per-filter partial tests
  hit_vec_t format_ok;
  hit_vec_t value_ok;
  hit_vec_t hit_next;

  // every filter evaluated in the same cycle
  always_comb begin
    for (int i = 0; i < num_filters; i++) begin
      format_ok[i] = (filter_table[i].ext == dec_id.ext);
      value_ok[i]  = ((dec_id.id & filter_table[i].mask) == filter_table[i].value);
      hit_next[i]  = filter_table[i].enable && format_ok[i] && value_ok[i];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hit_valid <= 1'b0;
    end else begin
      hit_valid <= dec_valid;
    end
  end

  // hit vector captured with the table as seen in the dec_valid cycle
  always_ff @(posedge clk) begin
    if (dec_valid) begin
      hits <= hit_next;
    end
  end

endmodule

// File: design/accept_result.sv
// Accept decision and hit index
`timescale 1ns/10ps

module accept_result (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          hit_valid,
  input  can_filter_pkg::hit_vec_t      hits,
  output logic                          result_valid,
  output can_filter_pkg::match_result_t result
);

  import can_filter_pkg::*;

  logic        any_hit;
  filter_idx_t low_index;

  assign any_hit = |hits;

  // scan down so the lowest set bit is written last
  // index stays zero when nothing matched
  always_comb begin
    low_index = '0;
    for (int i = num_filters - 1; i >= 0; i--) begin
      if (hits[i]) begin
        low_index = filter_idx_t'(i);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
      result       <= '0;
    end else begin
      result_valid <= hit_valid;
      if (hit_valid) begin
        result.accepted  <= any_hit;
        result.hit_index <= low_index;
      end
    end
  end

endmodule

// File: design/can_accept_filter.sv
// CAN acceptance filter top
`timescale 1ns/10ps

module can_accept_filter (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          cfg_wr,
  input  can_filter_pkg::filter_idx_t   cfg_index,
  input  can_filter_pkg::filter_entry_t cfg_entry,
  input  logic                          id_valid,
  input  can_filter_pkg::can_id_t       rx_id,
  input  logic                          rx_ide,
  output logic                          result_valid,
  output can_filter_pkg::match_result_t result
);

  import can_filter_pkg::*;

  // filter table, internal only
  filter_entry_t [num_filters-1:0] filter_table;

  // decode to match
  logic        dec_valid;
  decoded_id_t dec_id;

  // match to result
  logic     hit_valid;
  hit_vec_t hits;

  filter_bank u_filter_bank (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_wr       (cfg_wr),
    .cfg_index    (cfg_index),
    .cfg_entry    (cfg_entry),
    .filter_table (filter_table)
  );

  id_decode u_id_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .id_valid  (id_valid),
    .rx_id     (rx_id),
    .rx_ide    (rx_ide),
    .dec_valid (dec_valid),
    .dec_id    (dec_id)
  );

  mask_match u_mask_match (
    .clk          (clk),
    .rst_n        (rst_n),
    .dec_valid    (dec_valid),
    .dec_id       (dec_id),
    .filter_table (filter_table),
    .hit_valid    (hit_valid),
    .hits         (hits)
  );

  accept_result u_accept_result (
    .clk          (clk),
    .rst_n        (rst_n),
    .hit_valid    (hit_valid),
    .hits         (hits),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

// File: tb/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // reset held over the first five rising edges, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n <= 1'b1;
  end

endmodule

// File: tb/filter_checker.sv
// Result checker for the acceptance filter
`timescale 1ns/10ps

module filter_checker (
  input logic                          clk,
  input logic                          rst_n,
  input logic                          id_valid,
  input logic                          result_valid,
  input can_filter_pkg::match_result_t result
);

  import can_filter_pkg::*;

  // edges from the one that samples the strobe to the one that raises result_valid
  localparam int latency_edges = 3;

  int error_count = 0;
  int check_count = 0;

  match_result_t exp_queue[$];
  string         name_queue[$];
  int            strobe_edges[$];
  int            edge_count = 0;
  bit            reset_seen = 1'b0;

  task automatic expect_result(input string name, input match_result_t exp_res);
    exp_queue.push_back(exp_res);
    name_queue.push_back(name);
  endtask

  function automatic int pending();
    return exp_queue.size();
  endfunction

  task automatic report_missing();
    $display("expected result for %s never arrived, %0d results still outstanding",
             name_queue[0], exp_queue.size());
    error_count += exp_queue.size();
  endtask

  // strobes are stable at the rising edge, driven on the falling one
  always @(posedge clk) begin
    edge_count = edge_count + 1;
    if (rst_n && id_valid) begin
      strobe_edges.push_back(edge_count);
    end
  end

  // outputs sampled half a cycle after they change
  always @(negedge clk) begin
    match_result_t exp_res;
    string         name;
    int            edges;
    if (rst_n && !reset_seen) begin
      reset_seen = 1'b1;
      check_count++;
      if (result_valid !== 1'b0 || result !== '0) begin
        error_count++;
        $display("Fail after_reset: expected valid=0 result=0, actual valid=%0b result=%0h",
                 result_valid, result);
      end
    end
    if (rst_n && result_valid) begin
      if (exp_queue.size() == 0) begin
        error_count++;
        $display("result_valid pulsed with no frame outstanding");
      end else begin
        exp_res = exp_queue.pop_front();
        name    = name_queue.pop_front();
        edges   = 0;
        if (strobe_edges.size() != 0) begin
          edges = edge_count - strobe_edges.pop_front() + 1;
        end
        check_count++;
        if (result !== exp_res) begin
          error_count++;
          $display("Fail %s: expected accepted=%0b hit_index=%0d, actual accepted=%0b hit_index=%0d",
                   name, exp_res.accepted, exp_res.hit_index,
                   result.accepted, result.hit_index);
        end
        check_count++;
        if (edges != latency_edges) begin
          error_count++;
          $display("Fail %s latency: expected %0d edges, actual %0d edges",
                   name, latency_edges, edges);
        end
      end
    end
  end

endmodule

// File: tb/can_filter_assertions.sv
// Pipeline strobe and result assertions
`timescale 1ns/10ps

module can_filter_assertions (
  input logic                          clk,
  input logic                          rst_n,
  input logic                          dec_valid,
  input logic                          hit_valid,
  input logic                          result_valid,
  input can_filter_pkg::match_result_t result
);

  // each decoded ID reaches the match stage one cycle later
  dec_to_hit: assert property (@(posedge clk) disable iff (!rst_n)
    dec_valid |=> hit_valid)
    else $error("hit_valid missing one cycle after dec_valid");

  // no result without a hit strobe the cycle before
  no_stray_result: assert property (@(posedge clk) disable iff (!rst_n)
    !hit_valid |=> !result_valid)
    else $error("result_valid high without hit_valid the cycle before");

  // quiet decode stage means a quiet result two cycles on
  no_result_two_after: assert property (@(posedge clk) disable iff (!rst_n)
    !dec_valid |-> ##2 !result_valid)
    else $error("result_valid high two cycles after a cycle without dec_valid");

  // rejected frame reports filter zero
  reject_index_zero: assert property (@(posedge clk) disable iff (!rst_n)
    !result.accepted |-> (result.hit_index == '0))
    else $error("hit_index nonzero while accepted is low");

endmodule

// attached to the top, where every stage strobe is visible
bind can_accept_filter can_filter_assertions u_assertions (
  .clk          (clk),
  .rst_n        (rst_n),
  .dec_valid    (dec_valid),
  .hit_valid    (hit_valid),
  .result_valid (result_valid),
  .result       (result)
);

// File: tb/tb_can_accept_filter.sv
// CAN acceptance filter testbench
`timescale 1ns/10ps

module tb_can_accept_filter;

  import can_filter_pkg::*;

  localparam int reset_timeout = 50;
  localparam int drain_timeout = 50;

  typedef enum logic [1:0] {
    op_idle,
    op_cfg,
    op_id
  } row_op_t;

  // fields an op does not use stay zero
  typedef struct packed {
    row_op_t       op;
    filter_idx_t   index;
    filter_entry_t entry;
    can_id_t       id;
    logic          ide;
    match_result_t expect_res;
  } table_row_t;

  logic          clk;
  logic          rst_n;
  logic          cfg_wr;
  filter_idx_t   cfg_index;
  filter_entry_t cfg_entry;
  logic          id_valid;
  can_id_t       rx_id;
  logic          rx_ide;
  logic          result_valid;
  match_result_t result;

  table_row_t rows[$];
  string      row_names[$];
  bit         reset_ok;
  bit         timed_out;

  tb_clock_gen clock0 (
    .clk   (clk),
    .rst_n (rst_n)
  );

  can_accept_filter dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_wr       (cfg_wr),
    .cfg_index    (cfg_index),
    .cfg_entry    (cfg_entry),
    .id_valid     (id_valid),
    .rx_id        (rx_id),
    .rx_ide       (rx_ide),
    .result_valid (result_valid),
    .result       (result)
  );

  filter_checker checker0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .id_valid     (id_valid),
    .result_valid (result_valid),
    .result       (result)
  );

  task automatic config_row(input string name, input filter_idx_t index, input logic en,
                            input logic ext, input can_id_t mask, input can_id_t value);
    table_row_t row;
    row              = '0;
    row.op           = op_cfg;
    row.index        = index;
    row.entry.enable = en;
    row.entry.ext    = ext;
    row.entry.mask   = mask;
    row.entry.value  = value;
    rows.push_back(row);
    row_names.push_back(name);
  endtask

  task automatic expect_frame(input string name, input can_id_t id, input logic ide,
                              input logic acc, input filter_idx_t index);
    table_row_t row;
    row                      = '0;
    row.op                   = op_id;
    row.id                   = id;
    row.ide                  = ide;
    row.expect_res.accepted  = acc;
    row.expect_res.hit_index = index;
    rows.push_back(row);
    row_names.push_back(name);
  endtask

  // keeps filter writes clear of IDs still in the pipeline
  task automatic idle_gap(input int count);
    for (int i = 0; i < count; i++) begin
      rows.push_back('0);
      row_names.push_back("idle");
    end
  endtask

  task automatic build_table();
    // empty bank rejects everything
    expect_frame("rst_std_0", 29'h0000000, 1'b0, 1'b0, 3'd0);
    expect_frame("rst_std_7ff", 29'h00007FF, 1'b0, 1'b0, 3'd0);
    expect_frame("rst_ext_0", 29'h0000000, 1'b1, 1'b0, 3'd0);
    expect_frame("rst_ext_max", 29'h1FFFFFFF, 1'b1, 1'b0, 3'd0);
    idle_gap(3);
    // standard range 0x120 to 0x12F
    config_row("cfg_std_range", 3'd0, 1'b1, 1'b0, 29'h00007F0, 29'h0000120);
    // upper bits must be dropped by the bank
    config_row("cfg_std_upper", 3'd1, 1'b1, 1'b0, 29'h1FFFFFFF, 29'h1FFF0155);
    expect_frame("std_lo", 29'h0000120, 1'b0, 1'b1, 3'd0);
    expect_frame("std_mid", 29'h0000127, 1'b0, 1'b1, 3'd0);
    expect_frame("std_hi", 29'h000012F, 1'b0, 1'b1, 3'd0);
    expect_frame("std_above", 29'h0000130, 1'b0, 1'b0, 3'd0);
    expect_frame("std_below", 29'h000011F, 1'b0, 1'b0, 3'd0);
    expect_frame("ext_same_id", 29'h0000120, 1'b1, 1'b0, 3'd0);
    expect_frame("std_upper_junk", 29'h0F0A5125, 1'b0, 1'b1, 3'd0);
    expect_frame("std_cleared_upper", 29'h0000155, 1'b0, 1'b1, 3'd1);
    idle_gap(3);
    // exact extended match
    config_row("cfg_ext_exact", 3'd3, 1'b1, 1'b1, 29'h1FFFFFFF, 29'h12345678);
    expect_frame("ext_exact", 29'h12345678, 1'b1, 1'b1, 3'd3);
    expect_frame("ext_off_by_one", 29'h12345679, 1'b1, 1'b0, 3'd0);
    expect_frame("ext_exact_as_std", 29'h12345678, 1'b0, 1'b0, 3'd0);
    idle_gap(3);
    // extended wildcard
    config_row("cfg_ext_any", 3'd6, 1'b1, 1'b1, 29'h0000000, 29'h0000000);
    expect_frame("ext_any_0", 29'h0000000, 1'b1, 1'b1, 3'd6);
    expect_frame("ext_any_max", 29'h1FFFFFFF, 1'b1, 1'b1, 3'd6);
    expect_frame("ext_exact_again", 29'h12345678, 1'b1, 1'b1, 3'd3);
    expect_frame("std_not_any", 29'h0000000, 1'b0, 1'b0, 3'd0);
    idle_gap(3);
    // priority between filters 2 and 5
    config_row("cfg_prio_2", 3'd2, 1'b1, 1'b0, 29'h0000700, 29'h0000300);
    config_row("cfg_prio_5", 3'd5, 1'b1, 1'b0, 29'h00007FF, 29'h00003A5);
    expect_frame("prio_both", 29'h00003A5, 1'b0, 1'b1, 3'd2);
    expect_frame("prio_two_only", 29'h00003B0, 1'b0, 1'b1, 3'd2);
    idle_gap(3);
    config_row("cfg_prio_2_off", 3'd2, 1'b0, 1'b0, 29'h0000700, 29'h0000300);
    expect_frame("prio_after_off", 29'h00003A5, 1'b0, 1'b1, 3'd5);
    expect_frame("prio_two_gone", 29'h00003B0, 1'b0, 1'b0, 3'd0);
    // back to back strobes
    expect_frame("burst_a", 29'h0000120, 1'b0, 1'b1, 3'd0);
    expect_frame("burst_b", 29'h00003A5, 1'b0, 1'b1, 3'd5);
    expect_frame("burst_c", 29'h12345678, 1'b1, 1'b1, 3'd3);
    expect_frame("burst_d", 29'h00007FF, 1'b0, 1'b0, 3'd0);
    expect_frame("burst_e", 29'h00ABCDEF, 1'b1, 1'b1, 3'd6);
    expect_frame("burst_f", 29'h0000155, 1'b0, 1'b1, 3'd1);
  endtask

  task automatic apply_row(input table_row_t row, input string name);
    cfg_wr    = (row.op == op_cfg);
    cfg_index = row.index;
    cfg_entry = row.entry;
    id_valid  = (row.op == op_id);
    rx_id     = row.id;
    rx_ide    = row.ide;
    if (row.op == op_id) begin
      checker0.expect_result(name, row.expect_res);
    end
  endtask

  task automatic wait_reset(output bit ok);
    int waited;
    waited = 0;
    while (rst_n !== 1'b1 && waited < reset_timeout) begin
      @(negedge clk);
      waited++;
    end
    ok = (rst_n === 1'b1);
    if (!ok) begin
      $display("reset was never released within %0d cycles", reset_timeout);
    end
  endtask

  task automatic drain_results(output bit late);
    int waited;
    waited = 0;
    while (checker0.pending() != 0 && waited < drain_timeout) begin
      @(negedge clk);
      waited++;
    end
    late = (checker0.pending() != 0);
    if (late) begin
      checker0.report_missing();
    end
  endtask

  initial begin
    cfg_wr    = 1'b0;
    cfg_index = '0;
    cfg_entry = '0;
    id_valid  = 1'b0;
    rx_id     = '0;
    rx_ide    = 1'b0;
    timed_out = 1'b0;
    build_table();
    wait_reset(reset_ok);
    if (reset_ok) begin
      for (int r = 0; r < rows.size(); r++) begin
        apply_row(rows[r], row_names[r]);
        @(negedge clk);
      end
      apply_row('0, "idle");
      drain_results(timed_out);
      // short tail to catch a stray result strobe
      repeat (4) @(negedge clk);
    end
    $display("checks: %0d, errors: %0d", checker0.check_count, checker0.error_count);
    if (reset_ok && !timed_out && checker0.error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: all.f
design/can_filter_pkg.sv
design/filter_bank.sv
design/id_decode.sv
design/mask_match.sv
design/accept_result.sv
design/can_accept_filter.sv
tb/tb_clock_gen.sv
tb/filter_checker.sv
tb/can_filter_assertions.sv
tb/tb_can_accept_filter.sv

// File: Makefile
# Verilator build and run for the CAN acceptance filter

VERILATOR ?= verilator
TOP       ?= tb_can_accept_filter
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

SRCS := $(shell grep -v '^+' $(FILELIST))
EXE  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(EXE): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(EXE)
	./$(EXE) | tee $(LOG)
	@if grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
